/* design/rv_decode_pkg.sv */
package rv_decode_pkg;

    // Major opcodes, bits [6:0] of the instruction word.
    localparam logic [6:0] opc_r      = 7'b0110011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam logic [31:0] inst_ecall = 32'h0000_0073;
    localparam logic [31:0] inst_mret  = 32'h3020_0073;

    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;

    localparam logic [31:0] mcause_ecall = 32'd11;  // Environment call from M-mode.

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_eq   = 4'd4,
        alu_xor  = 4'd5,
        alu_or   = 4'd6,
        alu_and  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_reg  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_imm    = 2'd0,
        src2_reg    = 2'd1,
        src2_csr_or = 2'd2,  // Csrrs sets bits of the CSR.
        src2_csr_wr = 2'd3   // Csrrw replaces the CSR.
    } src2_sel_e;

    typedef struct packed {
        logic mstatus;
        logic mtvec;
        logic mepc;
        logic mcause;
    } csr_wen_t;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
    } if_id_t;

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic [2:0] funct3;
        alu_op_e    alu_op;
        src1_sel_e  src1_sel;
        src2_sel_e  src2_sel;
        logic       reg_wen;
        csr_wen_t   csr_wen;
        logic       mem_wen;
        logic       mem_ren;
        logic       branch;
        logic       branch_inv;  // Taken when the compare result is false.
        logic       jump;
        logic       ecall;
        logic       mret;
    } dec_ctrl_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] rd_value;
        logic        reg_wen;
        csr_wen_t    csr_wen;  // The mask alone picks the target CSR.
        logic [31:0] csr_value;
    } wb_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        dec_ctrl_t   ctrl;
        logic [31:0] imm;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
        logic [31:0] csr_value;
    } id_ex_t;

endpackage

/* design/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               inst,
    input  logic [31:0]               pc,
    input  logic                      inst_clear,
    input  logic                      pipe_stop,
    output rv_decode_pkg::if_id_t     if_id,
    output rv_decode_pkg::dec_ctrl_t  ctrl
);

    import rv_decode_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] csr_addr;
    logic        is_csr_op;

    // IF/ID latch. A clear inserts the all-zero bubble word.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (inst_clear) begin
            if_id <= '0;
        end else if (!pipe_stop) begin
            if_id.inst <= inst;
            if_id.pc   <= pc;
        end
    end

    assign opcode    = if_id.inst[6:0];
    assign funct3    = if_id.inst[14:12];
    assign funct7    = if_id.inst[31:25];
    assign csr_addr  = if_id.inst[31:20];
    assign is_csr_op = (opcode == opc_system) && (funct3 != 3'b000);

    always_comb begin
        ctrl        = '0;
        ctrl.rs1    = if_id.inst[19:15];
        ctrl.rs2    = if_id.inst[24:20];
        ctrl.rd     = if_id.inst[11:7];
        ctrl.funct3 = funct3;

        case (opcode)
            opc_r, opc_op_imm: begin
                case (funct3)
                    3'b000:  ctrl.alu_op = (opcode == opc_r && funct7[5]) ? alu_sub : alu_add;
                    3'b001:  ctrl.alu_op = alu_sll;
                    3'b010:  ctrl.alu_op = alu_slt;
                    3'b011:  ctrl.alu_op = alu_sltu;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b101:  ctrl.alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  ctrl.alu_op = alu_or;
                    default: ctrl.alu_op = alu_and;
                endcase
            end
            opc_branch: begin
                case (funct3[2:1])
                    2'b00:   ctrl.alu_op = alu_eq;
                    2'b10:   ctrl.alu_op = alu_slt;
                    2'b11:   ctrl.alu_op = alu_sltu;
                    default: ctrl.alu_op = alu_add;
                endcase
            end
            opc_system: ctrl.alu_op = (funct3 == 3'b010) ? alu_or : alu_add;
            default:    ctrl.alu_op = alu_add;  // Address and link arithmetic.
        endcase

        case (opcode)
            opc_lui:          ctrl.src1_sel = src1_zero;
            opc_auipc, opc_jal: ctrl.src1_sel = src1_pc;
            default:          ctrl.src1_sel = src1_reg;
        endcase

        if (opcode == opc_r || opcode == opc_branch) begin
            ctrl.src2_sel = src2_reg;
        end else if (opcode == opc_system && funct3 == 3'b010) begin
            ctrl.src2_sel = src2_csr_or;
        end else if (opcode == opc_system && funct3 == 3'b001) begin
            ctrl.src2_sel = src2_csr_wr;
        end else begin
            ctrl.src2_sel = src2_imm;
        end

        case (opcode)
            opc_r, opc_load, opc_op_imm, opc_jalr,
            opc_lui, opc_auipc, opc_jal: ctrl.reg_wen = 1'b1;
            opc_system:                  ctrl.reg_wen = is_csr_op;
            default:                     ctrl.reg_wen = 1'b0;
        endcase

        ctrl.csr_wen.mstatus = is_csr_op && (csr_addr == csr_mstatus);
        ctrl.csr_wen.mtvec   = is_csr_op && (csr_addr == csr_mtvec);
        ctrl.csr_wen.mepc    = is_csr_op && (csr_addr == csr_mepc);
        ctrl.csr_wen.mcause  = is_csr_op && (csr_addr == csr_mcause);

        ctrl.mem_wen    = (opcode == opc_store);
        ctrl.mem_ren    = (opcode == opc_load);
        ctrl.branch     = (opcode == opc_branch);
        ctrl.branch_inv = (opcode == opc_branch) &&
                          (funct3 == 3'b000 || funct3 == 3'b101 || funct3 == 3'b111);
        ctrl.jump       = (opcode == opc_jal) || (opcode == opc_jalr);
        ctrl.ecall      = (if_id.inst == inst_ecall);
        ctrl.mret       = (if_id.inst == inst_mret);
    end

endmodule

/* design/imm_gen.sv */
`timescale 1ns/100ps

module imm_gen (
    input  rv_decode_pkg::if_id_t if_id,
    output logic [31:0]           imm
);

    import rv_decode_pkg::*;

    logic [31:0] ins;

    assign ins = if_id.inst;

    always_comb begin
        case (ins[6:0])
            opc_load, opc_op_imm, opc_jalr, opc_system: begin
                imm = {20'd0, ins[31:20]};  // CSR ops read their address from here.
            end
            opc_store: begin
                imm = {20'd0, ins[31:25], ins[11:7]};
            end
            opc_lui, opc_auipc: begin
                imm = {12'd0, ins[31:12]};  // Execute does the shift by 12.
            end
            opc_jal: begin
                imm = {12'd0, ins[31], ins[19:12], ins[20], ins[30:21]};
            end
            opc_branch: begin
                imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            opc_r: begin
                imm = {25'd0, ins[31:25]};
            end
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rv_decode_pkg::dec_ctrl_t  ctrl,
    input  rv_decode_pkg::if_id_t     if_id,
    input  rv_decode_pkg::wb_t        wb,
    output logic [31:0]               rs1_value,
    output logic [31:0]               rs2_value,
    output logic [31:0]               csr_value,
    output logic [31:0]               mepc_out,
    output logic [31:0]               mtvec_out
);

    import rv_decode_pkg::*;

    logic [31:0] x_regs [1:31];  // x0 is not stored.
    logic [31:0] mstatus;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [11:0] csr_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                x_regs[i] <= '0;
            end
        end else if (wb.reg_wen && wb.rd != 5'd0) begin
            x_regs[wb.rd] <= wb.rd_value;
        end
    end

    // An ecall in decode wins over a writeback to mepc or mcause.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else begin
            if (wb.csr_wen.mstatus) mstatus <= wb.csr_value;
            if (wb.csr_wen.mtvec)   mtvec   <= wb.csr_value;
            if (ctrl.ecall) begin
                mepc   <= if_id.pc;
                mcause <= mcause_ecall;
            end else begin
                if (wb.csr_wen.mepc)   mepc   <= wb.csr_value;
                if (wb.csr_wen.mcause) mcause <= wb.csr_value;
            end
        end
    end

    assign rs1_value = (ctrl.rs1 == 5'd0) ? 32'd0 : x_regs[ctrl.rs1];
    assign rs2_value = (ctrl.rs2 == 5'd0) ? 32'd0 : x_regs[ctrl.rs2];

    assign csr_addr = if_id.inst[31:20];

    always_comb begin
        case (csr_addr)
            csr_mstatus: csr_value = mstatus;
            csr_mtvec:   csr_value = mtvec;
            csr_mepc:    csr_value = mepc;
            csr_mcause:  csr_value = mcause;
            default:     csr_value = 32'd0;
        endcase
    end

    assign mepc_out  = mepc;
    assign mtvec_out = mtvec;

endmodule

/* design/id_ex_reg.sv */
`timescale 1ns/100ps

module id_ex_reg (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inst_clear,
    input  logic                      pipe_stop,
    input  rv_decode_pkg::if_id_t     if_id,
    input  rv_decode_pkg::dec_ctrl_t  ctrl,
    input  logic [31:0]               imm,
    input  logic [31:0]               rs1_value,
    input  logic [31:0]               rs2_value,
    input  logic [31:0]               csr_value,
    output rv_decode_pkg::id_ex_t     id_ex
);

    import rv_decode_pkg::*;

    id_ex_t id_ex_d;

    always_comb begin
        id_ex_d.valid     = |if_id.inst;  // The zero word is a bubble.
        id_ex_d.pc        = if_id.pc;
        id_ex_d.inst      = if_id.inst;
        id_ex_d.ctrl      = ctrl;
        id_ex_d.imm       = imm;
        id_ex_d.rs1_value = rs1_value;
        id_ex_d.rs2_value = rs2_value;
        id_ex_d.csr_value = csr_value;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (inst_clear) begin
            id_ex <= '0;
        end else if (!pipe_stop) begin
            id_ex <= id_ex_d;
        end
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [31:0]            inst,
    input  logic [31:0]            pc,
    input  logic                   inst_clear,
    input  logic                   pipe_stop,
    input  rv_decode_pkg::wb_t     wb,
    output rv_decode_pkg::id_ex_t  id_ex,
    output logic [31:0]            mepc_out,
    output logic [31:0]            mtvec_out
);

    import rv_decode_pkg::*;

    if_id_t      if_id;
    dec_ctrl_t   ctrl;
    logic [31:0] imm;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] csr_value;

    inst_decoder i_inst_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .pc         (pc),
        .inst_clear (inst_clear),
        .pipe_stop  (pipe_stop),
        .if_id      (if_id),
        .ctrl       (ctrl)
    );

    imm_gen i_imm_gen (
        .if_id (if_id),
        .imm   (imm)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .if_id     (if_id),
        .wb        (wb),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .csr_value (csr_value),
        .mepc_out  (mepc_out),
        .mtvec_out (mtvec_out)
    );

    id_ex_reg i_id_ex_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_clear (inst_clear),
        .pipe_stop  (pipe_stop),
        .if_id      (if_id),
        .ctrl       (ctrl),
        .imm        (imm),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .csr_value  (csr_value),
        .id_ex      (id_ex)
    );

endmodule

/* test/decode_stage_tb.sv */
`timescale 1ns/100ps

module decode_stage_tb;

    import rv_decode_pkg::*;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        dec_ctrl_t   ctrl;
        logic [31:0] imm;
        logic        wb_en;  // Writes wb_rd in the cycle the operands are sampled.
        logic [4:0]  wb_rd;
    } vec_t;

    localparam int n_cases     = 18;
    localparam int cycle_limit = n_cases * 4 + 200;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        inst_clear;
    logic        pipe_stop;
    wb_t         wb;
    id_ex_t      id_ex;
    logic [31:0] mepc_out;
    logic [31:0] mtvec_out;

    vec_t        cases[$];
    string       names[$];
    logic [31:0] model_x [0:31];
    logic [31:0] model_mtvec;
    logic [31:0] model_mepc;
    logic [31:0] model_mcause;
    logic [31:0] rng;
    id_ex_t      held;
    int          cycle_count = 0;

    decode_stage i_decode_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .pc         (pc),
        .inst_clear (inst_clear),
        .pipe_stop  (pipe_stop),
        .wb         (wb),
        .id_ex      (id_ex),
        .mepc_out   (mepc_out),
        .mtvec_out  (mtvec_out)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("TEST FAILED");
            $fatal(1, "The run did not finish within %0d cycles.", cycle_limit);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] csr_model(input logic [11:0] addr);
        case (addr)
            csr_mtvec:  return model_mtvec;
            csr_mepc:   return model_mepc;
            csr_mcause: return model_mcause;
            default:    return 32'd0;  // mstatus keeps its reset value in this run.
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic fail_now(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            fail_now("A 32-bit result differs from its expected value.");
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            fail_now("The valid flag differs from its expected value.");
        end
    endtask

    task automatic check_ctrl(input string name, input dec_ctrl_t exp, input dec_ctrl_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            fail_now("The decoded control differs from its expected value.");
        end
    endtask

    task automatic check_payload(input string name, input id_ex_t exp, input id_ex_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            fail_now("The ID/EX payload differs from its expected value.");
        end
    endtask

    // Flags are {reg_wen, mem_wen, mem_ren, branch, branch_inv, jump, ecall, mret}.
    task automatic add_case(input string name, input logic [31:0] word, input alu_op_e alu,
                            input src1_sel_e s1, input src2_sel_e s2, input csr_wen_t cw,
                            input logic [7:0] flags, input logic [31:0] imm,
                            input logic [5:0] wr);
        vec_t v;
        v             = '0;
        v.inst        = word;
        v.pc          = 32'h100 + 32'(4 * cases.size());
        v.ctrl.rs1    = word[19:15];
        v.ctrl.rs2    = word[24:20];
        v.ctrl.rd     = word[11:7];
        v.ctrl.funct3 = word[14:12];
        v.ctrl.alu_op   = alu;
        v.ctrl.src1_sel = s1;
        v.ctrl.src2_sel = s2;
        v.ctrl.csr_wen  = cw;
        {v.ctrl.reg_wen, v.ctrl.mem_wen, v.ctrl.mem_ren, v.ctrl.branch,
         v.ctrl.branch_inv, v.ctrl.jump, v.ctrl.ecall, v.ctrl.mret} = flags;
        v.imm = imm;
        {v.wb_en, v.wb_rd} = wr;
        cases.push_back(v);
        names.push_back(name);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst         = '0;
        pc           = '0;
        inst_clear   = 1'b0;
        pipe_stop    = 1'b0;
        wb           = '0;
        rng          = 32'hf7724099;
        model_x[0]   = '0;
        model_mtvec  = '0;
        model_mepc   = '0;
        model_mcause = '0;

        add_case("add", 32'h002081b3, alu_add, src1_reg, src2_reg, 4'h0, 8'h80, 32'h0, 6'h21);
        add_case("sub", 32'h407302b3, alu_sub, src1_reg, src2_reg, 4'h0, 8'h80, 32'h20, 6'h0);
        add_case("sra", 32'h40a4d433, alu_sra, src1_reg, src2_reg, 4'h0, 8'h80, 32'h20, 6'h0);
        add_case("slti", 32'hffb62593, alu_slt, src1_reg, src2_imm, 4'h0, 8'h80, 32'hffb, 6'h0);
        add_case("sltu", 32'h00f736b3, alu_sltu, src1_reg, src2_reg, 4'h0, 8'h80, 32'h0, 6'h0);
        add_case("lw", 32'h0088a803, alu_add, src1_reg, src2_imm, 4'h0, 8'ha0, 32'h8, 6'h0);
        add_case("sw", 32'h0129a623, alu_add, src1_reg, src2_imm, 4'h0, 8'h40, 32'hc, 6'h0);
        add_case("beq", 32'hfe208ce3, alu_eq, src1_reg, src2_reg, 4'h0, 8'h18, 32'hfffffff8, 6'h0);
        add_case("bne", 32'h00419863, alu_eq, src1_reg, src2_reg, 4'h0, 8'h10, 32'h10, 6'h0);
        add_case("bgeu", 32'h0262f063, alu_sltu, src1_reg, src2_reg, 4'h0, 8'h18, 32'h20, 6'h0);
        add_case("jal", 32'h0010006f, alu_add, src1_pc, src2_imm, 4'h0, 8'h84, 32'h400, 6'h0);
        add_case("jalr", 32'h00408067, alu_add, src1_reg, src2_imm, 4'h0, 8'h84, 32'h4, 6'h20);
        add_case("lui", 32'h12345a37, alu_add, src1_zero, src2_imm, 4'h0, 8'h80, 32'h12345, 6'h0);
        add_case("auipc", 32'habcdea97, alu_add, src1_pc, src2_imm, 4'h0, 8'h80, 32'habcde, 6'h0);
        add_case("csrrw", 32'h305b9b73, alu_add, src1_reg, src2_csr_wr, 4'h4, 8'h80, 32'h305, 6'h0);
        add_case("ecall", 32'h00000073, alu_add, src1_reg, src2_imm, 4'h0, 8'h02, 32'h0, 6'h0);
        add_case("csrrs", 32'h34202c73, alu_or, src1_reg, src2_csr_or, 4'h1, 8'h80, 32'h342, 6'h0);
        add_case("mret", 32'h30200073, alu_add, src1_reg, src2_imm, 4'h0, 8'h01, 32'h302, 6'h0);

        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_payload("reset id_ex", '0, id_ex);
        check_word("reset mepc_out", 32'd0, mepc_out);
        check_word("reset mtvec_out", 32'd0, mtvec_out);

        for (int r = 1; r < 32; r++) begin
            rng         = xorshift(rng);
            model_x[r]  = rng;
            wb.reg_wen  = 1'b1;
            wb.rd       = 5'(r);
            wb.rd_value = rng;
            next_cycle();
        end
        wb               = '0;
        rng              = xorshift(rng);
        model_mtvec      = {rng[31:2], 2'b00};
        wb.csr_wen.mtvec = 1'b1;
        wb.csr_value     = model_mtvec;
        next_cycle();
        wb = '0;
        check_word("mtvec_out", model_mtvec, mtvec_out);

        for (int k = 0; k < cases.size(); k++) begin
            inst = cases[k].inst;
            pc   = cases[k].pc;
            next_cycle();
            inst = '0;
            pc   = '0;
            if (cases[k].wb_en) begin
                rng         = xorshift(rng);
                wb.reg_wen  = 1'b1;
                wb.rd       = cases[k].wb_rd;
                wb.rd_value = rng;
            end
            next_cycle();
            wb = '0;
            check_valid(names[k], 1'b1, id_ex.valid);
            check_word({names[k], " pc"}, cases[k].pc, id_ex.pc);
            check_word({names[k], " inst"}, cases[k].inst, id_ex.inst);
            check_ctrl(names[k], cases[k].ctrl, id_ex.ctrl);
            check_word({names[k], " imm"}, cases[k].imm, id_ex.imm);
            check_word({names[k], " rs1"}, model_x[cases[k].inst[19:15]], id_ex.rs1_value);
            check_word({names[k], " rs2"}, model_x[cases[k].inst[24:20]], id_ex.rs2_value);
            check_word({names[k], " csr"}, csr_model(cases[k].inst[31:20]), id_ex.csr_value);
            if (cases[k].wb_en && cases[k].wb_rd != 5'd0) begin
                model_x[cases[k].wb_rd] = rng;  // Later reads see the new value.
            end
            if (cases[k].ctrl.ecall) begin
                model_mepc   = cases[k].pc;
                model_mcause = 32'd11;
                check_word({names[k], " mepc_out"}, model_mepc, mepc_out);
            end
        end

        inst = 32'h12345a37;
        pc   = 32'h400;
        next_cycle();
        inst = 32'habcdea97;
        pc   = 32'h404;
        next_cycle();
        check_word("stall entry inst", 32'h12345a37, id_ex.inst);
        held      = id_ex;
        pipe_stop = 1'b1;
        for (int s = 0; s < 2; s++) begin
            inst = (s == 0) ? 32'h0010006f : 32'h00408067;  // Presented only while stalled.
            pc   = 32'h408 + 32'(4 * s);
            next_cycle();
            check_payload("stall hold", held, id_ex);
        end
        pipe_stop = 1'b0;
        inst      = 32'h12345a37;
        pc        = 32'h410;
        next_cycle();
        check_word("stall release inst", 32'habcdea97, id_ex.inst);
        check_word("stall release pc", 32'h404, id_ex.pc);

        inst_clear = 1'b1;
        inst       = 32'h0010006f;
        next_cycle();
        inst_clear = 1'b0;
        inst       = '0;
        pc         = '0;
        check_valid("clear valid", 1'b0, id_ex.valid);
        check_ctrl("clear ctrl", '0, id_ex.ctrl);
        check_payload("clear id_ex", '0, id_ex);
        next_cycle();
        check_payload("clear latch bubble", '0, id_ex);  // The IF/ID latch was zeroed too.

        $display("TEST OK");
        $finish;
    end

endmodule

/* all.f */
design/rv_decode_pkg.sv
design/inst_decoder.sv
design/imm_gen.sv
design/reg_file.sv
design/id_ex_reg.sv
design/decode_stage.sv
test/decode_stage_tb.sv

/* run.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it.
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module decode_stage_tb -f all.f -o decode_sim \
    && ./obj_dir/decode_sim \
    || exit 1
